// File: lsu_unit.f
+incdir+hdl
hdl/lsu_op_pkg.sv
hdl/lsu_mem_pkg.sv
hdl/lsu_commit_if.sv
hdl/lsu_elastic_buf.sv
hdl/lsu_req_format.sv
hdl/lsu_load_align.sv
hdl/lsu_commit_arb.sv
hdl/lsu_unit.sv
verif/lsu_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_unit_tb \
    -f lsu_unit.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vlsu_unit_tb > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"
grep -q "all tests passed" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/lsu_unit_tb.sv
// testbench for the load/store unit
// clock and reset, LCG stimulus, data-cache model, shadow memory,
// concurrent checks on memory requests and commits

`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_unit_tb;
    localparam int N_OPS   = 300;
    localparam int TIMEOUT = 500;

    typedef struct packed {
        logic [`LSU_WID_BITS-1:0] wid;
        logic [`LSU_XLEN-1:0]     pc;
        logic [`LSU_NR_BITS-1:0]  rd;
        logic [`LSU_XLEN-1:0]     data;
    } commit_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]             data;
        logic [lsu_mem_pkg::TAG_BITS-1:0] tag;
        logic [31:0]                      due;
    } rsp_t;

    logic clk, reset, dispatch_valid, dispatch_ready;
    logic [`LSU_WID_BITS-1:0] dispatch_wid, commit_wid;
    logic [`LSU_XLEN-1:0] dispatch_pc, dispatch_rs1, dispatch_rs2, dispatch_imm;
    lsu_op_pkg::lsu_op_e dispatch_op;
    logic [`LSU_NR_BITS-1:0] dispatch_rd, commit_rd;
    logic mem_req_valid, mem_req_rw, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    logic [`LSU_WADDR_BITS-1:0] mem_req_addr;
    logic [`LSU_WORD_BYTES-1:0] mem_req_byteen, exp_byteen;
    logic [`LSU_XLEN-1:0] mem_req_data, mem_rsp_data, commit_pc, commit_data, exp_data;
    logic [lsu_mem_pkg::TAG_BITS-1:0] mem_req_tag, mem_rsp_tag;
    logic commit_valid, commit_ready, commit_wb;

    logic [31:0] lcg_state = 32'h88cb;
    logic [31:0] cycle;
    logic [31:0] mem [64];
    logic [31:0] shadow [64];
    rsp_t        rsp_q [$];
    commit_t     ld_q [$];
    commit_t     st_q [$];
    commit_t     ld_head, st_head;
    int          ld_sent, st_sent, ld_done, st_done, ld_pend, st_pend;

    lsu_op_pkg::lsu_op_e op_table [8] = '{lsu_op_pkg::LB, lsu_op_pkg::LH, lsu_op_pkg::LW,
        lsu_op_pkg::LBU, lsu_op_pkg::LHU, lsu_op_pkg::SB, lsu_op_pkg::SH, lsu_op_pkg::SW};

    lsu_unit dut (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // addressed byte or half with the extension of its opcode
    function automatic logic [31:0] load_value(input logic [31:0] word,
                                               input lsu_op_pkg::lsu_op_e op,
                                               input logic [1:0] off);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op)
            lsu_op_pkg::LB:  return {{24{sh[7]}}, sh[7:0]};
            lsu_op_pkg::LH:  return {{16{sh[15]}}, sh[15:0]};
            lsu_op_pkg::LBU: return {24'h0, sh[7:0]};
            lsu_op_pkg::LHU: return {16'h0, sh[15:0]};
            default:         return word;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] word,
                                                input lsu_op_pkg::lsu_op_e op,
                                                input logic [1:0] off,
                                                input logic [31:0] value);
        logic [31:0] res;
        res = word;
        case (op)
            lsu_op_pkg::SB: res[8*off +: 8] = value[7:0];
            lsu_op_pkg::SH: res[8*off +: 16] = value[15:0];
            default:        res = value;
        endcase
        return res;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cache-side ready, commit stalls, in-order read responses
    always @(negedge clk) begin
        mem_req_ready = (next_rand() % 8) != 0;
        commit_ready  = (next_rand() % 4) != 0;
        mem_rsp_valid = (rsp_q.size() != 0) && (rsp_q[0].due <= cycle);
        if (rsp_q.size() != 0) begin
            mem_rsp_data = rsp_q[0].data;
            mem_rsp_tag  = rsp_q[0].tag;
        end
    end

    always @(posedge clk) begin
        int          b;
        rsp_t        rsp;
        commit_t     rec;
        logic [31:0] eff;
        cycle = cycle + 1;
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req_rw) begin
                for (b = 0; b < 4; b++) begin
                    if (mem_req_byteen[b]) begin
                        mem[mem_req_addr[5:0]][8*b +: 8] = mem_req_data[8*b +: 8];
                    end
                end
            end else begin
                rsp.data = mem[mem_req_addr[5:0]];
                rsp.tag  = mem_req_tag;
                rsp.due  = cycle + 1 + (next_rand() % 6);
                rsp_q.push_back(rsp);
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            void'(rsp_q.pop_front());
        end
        if (dispatch_valid && dispatch_ready) begin
            eff = dispatch_rs1 + dispatch_imm;
            rec = '{wid: dispatch_wid, pc: dispatch_pc, rd: '0, data: '0};
            if (dispatch_op[3]) begin
                shadow[eff[7:2]] = store_merge(shadow[eff[7:2]], dispatch_op, eff[1:0],
                                               dispatch_rs2);
                st_q.push_back(rec);
                st_sent++;
            end else begin
                rec.rd   = dispatch_rd;
                rec.data = load_value(shadow[eff[7:2]], dispatch_op, eff[1:0]);
                ld_q.push_back(rec);
                ld_sent++;
            end
        end
        if (commit_valid && commit_ready) begin
            if (commit_wb) begin
                ld_done++;
                if (ld_q.size() != 0) void'(ld_q.pop_front());
            end else begin
                st_done++;
                if (st_q.size() != 0) void'(st_q.pop_front());
            end
        end
        ld_head = (ld_q.size() != 0) ? ld_q[0] : '0;
        st_head = (st_q.size() != 0) ? st_q[0] : '0;
        ld_pend = ld_q.size();
        st_pend = st_q.size();
    end

    wire wr_fire = mem_req_valid && mem_req_ready && mem_req_rw;
    wire ld_fire = commit_valid && commit_ready && commit_wb;
    wire st_fire = commit_valid && commit_ready && !commit_wb;

    reset_req: assert property (@(posedge clk) reset |=> !mem_req_valid)
        else stop_on_error($sformatf("FAIL mem_req_valid got %h expected 0",
                                     $sampled(mem_req_valid)));
    reset_commit: assert property (@(posedge clk) reset |=> !commit_valid)
        else stop_on_error($sformatf("FAIL commit_valid got %h expected 0",
                                     $sampled(commit_valid)));
    st_byteen: assert property (@(posedge clk) disable iff (reset)
        wr_fire |-> mem_req_byteen == exp_byteen)
        else stop_on_error($sformatf("FAIL mem_req_byteen got %h expected %h",
                                     $sampled(mem_req_byteen), $sampled(exp_byteen)));
    st_data: assert property (@(posedge clk) disable iff (reset)
        wr_fire |-> mem_req_data == exp_data)
        else stop_on_error($sformatf("FAIL mem_req_data got %h expected %h",
                                     $sampled(mem_req_data), $sampled(exp_data)));
    ld_known: assert property (@(posedge clk) disable iff (reset) ld_fire |-> ld_pend != 0)
        else stop_on_error("load commit arrived with no load outstanding");
    st_known: assert property (@(posedge clk) disable iff (reset) st_fire |-> st_pend != 0)
        else stop_on_error("store commit arrived with no store outstanding");
    ld_pc: assert property (@(posedge clk) disable iff (reset) ld_fire |-> commit_pc == ld_head.pc)
        else stop_on_error($sformatf("FAIL commit_pc got %h expected %h",
                                     $sampled(commit_pc), $sampled(ld_head.pc)));
    ld_rd: assert property (@(posedge clk) disable iff (reset) ld_fire |-> commit_rd == ld_head.rd)
        else stop_on_error($sformatf("FAIL commit_rd got %h expected %h",
                                     $sampled(commit_rd), $sampled(ld_head.rd)));
    ld_data: assert property (@(posedge clk) disable iff (reset)
        ld_fire |-> commit_data == ld_head.data)
        else stop_on_error($sformatf("FAIL commit_data got %h expected %h",
                                     $sampled(commit_data), $sampled(ld_head.data)));
    st_pc: assert property (@(posedge clk) disable iff (reset) st_fire |-> commit_pc == st_head.pc)
        else stop_on_error($sformatf("FAIL commit_pc got %h expected %h",
                                     $sampled(commit_pc), $sampled(st_head.pc)));
    st_zero: assert property (@(posedge clk) disable iff (reset)
        st_fire |-> commit_rd == '0 && commit_data == '0)
        else stop_on_error($sformatf("FAIL commit_rd/commit_data got %h/%h expected 0/0",
                                     $sampled(commit_rd), $sampled(commit_data)));
    wid_match: assert property (@(posedge clk) disable iff (reset)
        (ld_fire || st_fire) |-> commit_wid == (commit_wb ? ld_head.wid : st_head.wid))
        else stop_on_error($sformatf("FAIL commit_wid got %h expected %h",
                                     $sampled(commit_wid),
                                     $sampled(commit_wb) ? $sampled(ld_head.wid)
                                                         : $sampled(st_head.wid)));
    commit_hold: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> commit_valid
            && $stable({commit_wid, commit_pc, commit_rd, commit_wb, commit_data}))
        else stop_on_error("commit outputs changed while commit_ready was low");

    initial begin
        int                  i;
        int                  n;
        logic [31:0]         addr;
        logic [1:0]          off;
        lsu_op_pkg::lsu_op_e op;
        logic                accepted;
        logic                drained;
        for (i = 0; i < 64; i++) begin
            mem[i]    = 32'hc3a5_0000 ^ (i * 32'h0104_1041);
            shadow[i] = mem[i];
        end
        {ld_sent, st_sent, ld_done, st_done, ld_pend, st_pend} = '0;
        cycle = 0;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_wid = '0;
        dispatch_pc = '0;
        dispatch_op = lsu_op_pkg::LB;
        dispatch_rd = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_imm = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_rsp_tag = '0;
        commit_ready = 1'b0;
        exp_byteen = '0;
        exp_data = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        for (i = 0; i < N_OPS; i++) begin
            op  = op_table[next_rand() % 8];
            off = 2'(next_rand());
            if (op == lsu_op_pkg::LH || op == lsu_op_pkg::LHU || op == lsu_op_pkg::SH)
                off[0] = 1'b0;
            if (op == lsu_op_pkg::LW || op == lsu_op_pkg::SW)
                off = 2'b00;
            addr = {24'h0, 6'(next_rand()), off};
            dispatch_op  = op;
            dispatch_wid = 2'(next_rand());
            dispatch_rd  = 5'(next_rand());
            dispatch_pc  = 32'h0000_1000 + 4 * i;
            dispatch_rs1 = next_rand();
            dispatch_imm = addr - dispatch_rs1;
            dispatch_rs2 = next_rand();
            // request lanes and data shifted to the offset
            if (op == lsu_op_pkg::SB)
                exp_byteen = 4'b0001 << off;
            else if (op == lsu_op_pkg::SH)
                exp_byteen = 4'b0011 << off;
            else
                exp_byteen = 4'b1111;
            exp_data = dispatch_rs2 << (8 * off);
            dispatch_valid = 1'b1;
            accepted = 1'b0;
            for (n = 0; n < TIMEOUT && !accepted; n++) begin
                @(posedge clk);
                accepted = dispatch_ready;
            end
            if (!accepted)
                stop_on_error("dispatch was not accepted before the timeout");
            @(negedge clk);
            dispatch_valid = 1'b0;
            repeat (next_rand() % 3) @(negedge clk);
        end

        drained = 1'b0;
        for (n = 0; n < 4 * TIMEOUT && !drained; n++) begin
            @(negedge clk);
            drained = (ld_done == ld_sent) && (st_done == st_sent) && !commit_valid;
        end
        if (drained) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_on_error("pipeline did not drain, commit counts differ from dispatch counts");
        end
    end

endmodule

// File: hdl/lsu_unit.sv
// lsu_unit: single-lane load/store unit top level
// request formatter, load-align path, commit arbiter

`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_unit (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             dispatch_valid,
    output logic                             dispatch_ready,
    input  logic [`LSU_WID_BITS-1:0]         dispatch_wid,
    input  logic [`LSU_XLEN-1:0]             dispatch_pc,
    input  lsu_op_pkg::lsu_op_e              dispatch_op,
    input  logic [`LSU_NR_BITS-1:0]          dispatch_rd,
    input  logic [`LSU_XLEN-1:0]             dispatch_rs1,
    input  logic [`LSU_XLEN-1:0]             dispatch_rs2,
    input  logic [`LSU_XLEN-1:0]             dispatch_imm,
    output logic                             mem_req_valid,
    output logic                             mem_req_rw,
    output logic [`LSU_WADDR_BITS-1:0]       mem_req_addr,
    output logic [`LSU_WORD_BYTES-1:0]       mem_req_byteen,
    output logic [`LSU_XLEN-1:0]             mem_req_data,
    output logic [lsu_mem_pkg::TAG_BITS-1:0] mem_req_tag,
    input  logic                             mem_req_ready,
    input  logic                             mem_rsp_valid,
    input  logic [`LSU_XLEN-1:0]             mem_rsp_data,
    input  logic [lsu_mem_pkg::TAG_BITS-1:0] mem_rsp_tag,
    output logic                             mem_rsp_ready,
    output logic                             commit_valid,
    input  logic                             commit_ready,
    output logic [`LSU_WID_BITS-1:0]         commit_wid,
    output logic [`LSU_XLEN-1:0]             commit_pc,
    output logic [`LSU_NR_BITS-1:0]          commit_rd,
    output logic                             commit_wb,
    output logic [`LSU_XLEN-1:0]             commit_data
);
    lsu_ld_commit_if ld_commit ();
    lsu_st_commit_if st_commit ();

    lsu_req_format req_format (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_wid   (dispatch_wid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .st_commit      (st_commit.src)
    );

    lsu_load_align load_align (
        .clk           (clk),
        .reset         (reset),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .ld_commit     (ld_commit.src)
    );

    lsu_commit_arb commit_arb (
        .clk          (clk),
        .reset        (reset),
        .ld_commit    (ld_commit.dst),
        .st_commit    (st_commit.dst),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

// File: hdl/lsu_commit_arb.sv
// load and store commit merge
// round-robin grant and registered commit output

`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_commit_arb (
    input  logic                     clk,
    input  logic                     reset,
    lsu_ld_commit_if.dst             ld_commit,
    lsu_st_commit_if.dst             st_commit,
    output logic                     commit_valid,
    output logic [`LSU_WID_BITS-1:0] commit_wid,
    output logic [`LSU_XLEN-1:0]     commit_pc,
    output logic [`LSU_NR_BITS-1:0]  commit_rd,
    output logic                     commit_wb,
    output logic [`LSU_XLEN-1:0]     commit_data,
    input  logic                     commit_ready
);
    logic out_free;
    logic grant_ld;
    logic grant_st;
    logic take;
    logic last_ld;

    assign out_free = commit_ready || !commit_valid;

    // on a tie the side not served last wins
    assign grant_ld = ld_commit.valid && (!st_commit.valid || !last_ld);
    assign grant_st = st_commit.valid && !grant_ld;
    assign take     = out_free && (grant_ld || grant_st);

    assign ld_commit.ready = out_free && grant_ld;
    assign st_commit.ready = out_free && grant_st;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            last_ld      <= 1'b0;
        end else begin
            if (out_free) begin
                commit_valid <= grant_ld || grant_st;
            end
            if (take) begin
                last_ld <= grant_ld;
            end
        end
    end

    // stores write back nothing
    always_ff @(posedge clk) begin
        if (take) begin
            commit_wid  <= grant_ld ? ld_commit.wid : st_commit.wid;
            commit_pc   <= grant_ld ? ld_commit.pc : st_commit.pc;
            commit_rd   <= grant_ld ? ld_commit.rd : '0;
            commit_wb   <= grant_ld;
            commit_data <= grant_ld ? ld_commit.data : '0;
        end
    end

    // each path keeps its offer until granted
    ld_offer_hold: assert property (@(posedge clk) disable iff (reset)
        (ld_commit.valid && !ld_commit.ready) |=> (ld_commit.valid
            && $stable({ld_commit.wid, ld_commit.pc, ld_commit.rd, ld_commit.data})))
        else $error("load commit withdrawn before grant");

    st_offer_hold: assert property (@(posedge clk) disable iff (reset)
        (st_commit.valid && !st_commit.ready) |=> (st_commit.valid
            && $stable({st_commit.wid, st_commit.pc})))
        else $error("store commit withdrawn before grant");

endmodule

// File: hdl/lsu_load_align.sv
// lsu_load_align: load response formatting
// tag decode, byte/half selection, sign or zero extension, result buffer

`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_load_align (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             mem_rsp_valid,
    output logic                             mem_rsp_ready,
    input  logic [`LSU_XLEN-1:0]             mem_rsp_data,
    input  logic [lsu_mem_pkg::TAG_BITS-1:0] mem_rsp_tag,
    lsu_ld_commit_if.src                     ld_commit
);
    localparam int LD_BITS = `LSU_WID_BITS + `LSU_XLEN + `LSU_NR_BITS + `LSU_XLEN;

    lsu_mem_pkg::lsu_tag_t  rsp_tag;
    lsu_mem_pkg::lsu_word_u rsp_word;
    logic [3:0]             rsp_op;
    lsu_op_pkg::lsu_size_e  rsp_size;
    logic                   rsp_zext;
    logic [7:0]             rsp_byte;
    logic [15:0]            rsp_half;
    logic [`LSU_XLEN-1:0]   rsp_data;
    logic [LD_BITS-1:0]     ld_out;

    assign rsp_tag  = mem_rsp_tag;
    assign rsp_word = mem_rsp_data;
    assign rsp_op   = rsp_tag.op;
    assign rsp_size = lsu_op_pkg::lsu_size_e'(rsp_op[1:0]);
    assign rsp_zext = (lsu_op_pkg::lsu_sign_e'(rsp_op[2]) == lsu_op_pkg::ZERO_EXT);

    // byte by full offset, half by its upper bit
    assign rsp_byte = rsp_word.bytes[rsp_tag.offset];
    assign rsp_half = rsp_word.halves[rsp_tag.offset[1]];

    always_comb begin
        case (rsp_size)
            lsu_op_pkg::SIZE_B:
                rsp_data = {{(`LSU_XLEN-8){rsp_byte[7] & ~rsp_zext}}, rsp_byte};
            lsu_op_pkg::SIZE_H:
                rsp_data = {{(`LSU_XLEN-16){rsp_half[15] & ~rsp_zext}}, rsp_half};
            default:
                rsp_data = rsp_word;
        endcase
    end

    lsu_elastic_buf #(
        .DATAW (LD_BITS)
    ) ld_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_rsp_valid),
        .ready_in  (mem_rsp_ready),
        .data_in   ({rsp_tag.wid, rsp_tag.pc, rsp_tag.rd, rsp_data}),
        .valid_out (ld_commit.valid),
        .ready_out (ld_commit.ready),
        .data_out  (ld_out)
    );

    assign {ld_commit.wid, ld_commit.pc, ld_commit.rd, ld_commit.data} = ld_out;

endmodule

// File: hdl/lsu_req_format.sv
// lsu_req_format: dispatch to data-cache request
// effective address, byte enables, store data alignment, request tag,
// store-commit buffering

`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_req_format (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                dispatch_valid,
    output logic                                dispatch_ready,
    input  logic [`LSU_WID_BITS-1:0]            dispatch_wid,
    input  logic [`LSU_XLEN-1:0]                dispatch_pc,
    input  lsu_op_pkg::lsu_op_e                 dispatch_op,
    input  logic [`LSU_NR_BITS-1:0]             dispatch_rd,
    input  logic [`LSU_XLEN-1:0]                dispatch_rs1,
    input  logic [`LSU_XLEN-1:0]                dispatch_rs2,
    input  logic [`LSU_XLEN-1:0]                dispatch_imm,
    output logic                                mem_req_valid,
    output logic                                mem_req_rw,
    output logic [`LSU_WADDR_BITS-1:0]          mem_req_addr,
    output logic [`LSU_WORD_BYTES-1:0]          mem_req_byteen,
    output logic [`LSU_XLEN-1:0]                mem_req_data,
    output logic [lsu_mem_pkg::TAG_BITS-1:0]    mem_req_tag,
    input  logic                                mem_req_ready,
    lsu_st_commit_if.src                        st_commit
);
    localparam int ST_BITS = `LSU_WID_BITS + `LSU_XLEN;

    logic [`LSU_XLEN-1:0]       full_addr;
    logic [`LSU_ALIGN_BITS-1:0] req_align;
    logic                       is_store;
    lsu_op_pkg::lsu_size_e      req_size;
    logic                       misaligned;
    logic                       st_buf_ready;
    logic                       st_push;
    logic [ST_BITS-1:0]         st_out;
    lsu_mem_pkg::lsu_tag_t      req_tag;

    assign full_addr    = dispatch_rs1 + dispatch_imm;
    assign req_align    = full_addr[`LSU_ALIGN_BITS-1:0];
    assign mem_req_addr = full_addr[`LSU_XLEN-1:`LSU_ALIGN_BITS];

    assign is_store = dispatch_op[3];
    assign req_size = lsu_op_pkg::lsu_size_e'(dispatch_op[1:0]);

    always_comb begin
        mem_req_byteen = '0;
        case (req_size)
            lsu_op_pkg::SIZE_B: mem_req_byteen[req_align] = 1'b1;
            lsu_op_pkg::SIZE_H: begin
                mem_req_byteen[{req_align[1], 1'b0}] = 1'b1;
                mem_req_byteen[{req_align[1], 1'b1}] = 1'b1;
            end
            default: mem_req_byteen = '1;
        endcase
    end

    // narrow store data moves up to its byte lane
    assign mem_req_data = dispatch_rs2 << {req_align, 3'b000};

    assign misaligned = ((req_size == lsu_op_pkg::SIZE_H) && req_align[0])
                     || ((req_size == lsu_op_pkg::SIZE_W) && (req_align != '0));

    assign req_tag.wid    = dispatch_wid;
    assign req_tag.pc     = dispatch_pc;
    assign req_tag.rd     = dispatch_rd;
    assign req_tag.op     = dispatch_op;
    assign req_tag.offset = req_align;
    assign mem_req_tag    = req_tag;

    // a store goes out only with room for its commit
    assign mem_req_valid  = dispatch_valid && (!is_store || st_buf_ready);
    assign dispatch_ready = mem_req_ready && (!is_store || st_buf_ready);
    assign mem_req_rw     = is_store;
    assign st_push        = mem_req_valid && mem_req_ready && is_store;

    lsu_elastic_buf #(
        .DATAW (ST_BITS)
    ) st_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (st_push),
        .ready_in  (st_buf_ready),
        .data_in   ({dispatch_wid, dispatch_pc}),
        .valid_out (st_commit.valid),
        .ready_out (st_commit.ready),
        .data_out  (st_out)
    );

    assign {st_commit.wid, st_commit.pc} = st_out;

    misaligned_access: assert property (@(posedge clk) disable iff (reset)
        (dispatch_valid && dispatch_ready) |-> !misaligned)
        else $error("misaligned access pc=%h addr=%h", dispatch_pc, full_addr);

endmodule

// File: hdl/lsu_elastic_buf.sv
// two-entry valid/ready buffer
// output register plus one skid entry

`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_elastic_buf #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic [1:0]       n_used;
    logic             push;
    logic             out_free;

    assign n_used   = {1'b0, valid_out} + {1'b0, skid_valid};
    assign ready_in = (n_used != 2'(`LSU_BUF_DEPTH));
    assign push     = valid_in && ready_in;
    assign out_free = ready_out || !valid_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            valid_out  <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    // skid entry drains first as the older item
    always_ff @(posedge clk) begin
        if (out_free) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (push && !out_free) begin
            skid_data <= data_in;
        end
    end

    // an item offered while full waits for room
    input_hold: assert property (@(posedge clk) disable iff (reset)
        (valid_in && !ready_in) |=> (valid_in && $stable(data_in)))
        else $error("elastic buffer input dropped while full");

endmodule

// File: hdl/lsu_commit_if.sv
// commit interfaces between the internal paths
// lsu_ld_commit_if: load results from the load-align path
// lsu_st_commit_if: store completions from the request formatter

`timescale 1ns/10ps
`include "lsu_consts.svh"

interface lsu_ld_commit_if;
    logic                     valid;
    logic                     ready;
    logic [`LSU_WID_BITS-1:0] wid;
    logic [`LSU_XLEN-1:0]     pc;
    logic [`LSU_NR_BITS-1:0]  rd;
    logic [`LSU_XLEN-1:0]     data;

    modport src (
        output valid, wid, pc, rd, data,
        input  ready
    );

    modport dst (
        input  valid, wid, pc, rd, data,
        output ready
    );
endinterface

// stores write nothing back, so no rd or data
interface lsu_st_commit_if;
    logic                     valid;
    logic                     ready;
    logic [`LSU_WID_BITS-1:0] wid;
    logic [`LSU_XLEN-1:0]     pc;

    modport src (
        output valid, wid, pc,
        input  ready
    );

    modport dst (
        input  valid, wid, pc,
        output ready
    );
endinterface

// File: hdl/lsu_mem_pkg.sv
// memory-side types of the load/store unit
// request tag carried through the cache, word views of a response

`include "lsu_consts.svh"

package lsu_mem_pkg;

    // everything the load path needs back from a response
    typedef struct packed {
        logic [`LSU_WID_BITS-1:0]   wid;
        logic [`LSU_XLEN-1:0]       pc;
        logic [`LSU_NR_BITS-1:0]    rd;
        lsu_op_pkg::lsu_op_e        op;
        logic [`LSU_ALIGN_BITS-1:0] offset;
    } lsu_tag_t;

    localparam int TAG_BITS = $bits(lsu_tag_t);

    // one memory word, as bytes or as halves
    typedef union packed {
        logic [`LSU_WORD_BYTES-1:0][7:0]       bytes;
        logic [`LSU_WORD_BYTES/2-1:0][15:0]    halves;
    } lsu_word_u;

endpackage

// File: hdl/lsu_op_pkg.sv
// instruction-side types of the load/store unit
// opcode enum, access size, load extension kind

package lsu_op_pkg;

    // top bit marks a store, bit 2 a zero-extending load,
    // low two bits give the access size
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } lsu_size_e;

    // sign or zero extension of a narrow load
    typedef enum logic {
        SIGN_EXT = 1'b0,
        ZERO_EXT = 1'b1
    } lsu_sign_e;

endpackage

// File: hdl/lsu_consts.svh
// widths and sizes of the load/store unit
// data path, addressing, register and warp fields, buffer depth

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 32

// one cache word per request
`define LSU_WORD_BYTES 4
`define LSU_ALIGN_BITS 2
`define LSU_WADDR_BITS 30

// register number
`define LSU_NR_BITS 5

// warp id
`define LSU_WID_BITS 2

// entries per elastic buffer
`define LSU_BUF_DEPTH 2

`endif
